// ==== dv/csr_unit_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit_properties (
  input wire logic                        clk_i,
  input wire logic                        rst_n_i,
  input wire logic                        csr_cmd_v_i,
  input wire logic [`CSR_ADDR_WIDTH-1:0]  csr_addr_i,
  input wire logic                        csr_illegal_o,
  input wire logic                        retire_v_i,
  input wire logic                        mret_i,
  input wire logic                        trap_v_o,
  input csr_isa_pkg::priv_e               priv_o,
  input wire logic [`CSR_VADDR_WIDTH-1:0] pc_o
);

  import csr_isa_pkg::*;

  int fail_count = 0;

  // Boot privilege holds through reset and on the first edge after it
  reset_priv_m: assert property (@(posedge clk_i)
    (!rst_n_i || $rose(rst_n_i)) |-> priv_o == e_priv_m)
  else
  begin
    fail_count++;
    $error("priv_o is not M around reset");
  end

  trap_to_m: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (trap_v_o && !mret_i) |=> priv_o == e_priv_m)
  else
  begin
    fail_count++;
    $error("trap did not enter M mode");
  end

  // Machine addresses are out of reach from U
  user_reaches_machine: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (csr_cmd_v_i && priv_o == e_priv_u && csr_addr_i[9:8] != 2'b00) |-> csr_illegal_o)
  else
  begin
    fail_count++;
    $error("machine CSR accessed from U mode without csr_illegal_o");
  end

  pc_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!retire_v_i && !trap_v_o && !mret_i) |=> $stable(pc_o))
  else
  begin
    fail_count++;
    $error("pc_o moved with no retire, trap or mret");
  end

endmodule

bind csr_unit csr_unit_properties u_props (.*);

`default_nettype wire

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit_tb;

  import csr_isa_pkg::*;
  import csr_trap_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int PHASE_CYCLES = 400;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + 6 * PHASE_CYCLES) * 20 + 2000;

  logic                       clk;
  logic                       rst_n;
  logic                       cmd_v;
  csr_op_e                    cmd_op;
  logic [11:0]                cmd_addr;
  logic [63:0]                cmd_wdata;
  logic                       retire_v;
  logic [38:0]                retire_npc;
  logic [EXC_VEC_WIDTH-1:0]   exc;
  logic [63:0]                exc_tval;
  logic                       int_take;
  logic                       mret;
  logic                       timer_irq;
  logic                       sw_irq;
  logic                       ext_irq;
  logic [63:0]                rdata;
  logic                       illegal;
  logic                       irq_pending;
  logic                       trap_v;
  logic [38:0]                pc;
  logic [38:0]                npc;
  priv_e                      priv;

  // Reference model state
  logic [1:0]                 m_priv;
  logic [38:0]                m_pc;
  logic [63:0]                m_mstatus, m_mie, m_mip, m_mtvec, m_mscratch, m_mepc;
  logic [63:0]                m_mcause, m_mtval, m_mcycle, m_minstret, m_inhibit;

  logic [15:0]                lfsr = 16'd24;
  string                      test_name;

  csr_unit DUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .csr_cmd_v_i    (cmd_v),
    .csr_op_i       (cmd_op),
    .csr_addr_i     (cmd_addr),
    .csr_wdata_i    (cmd_wdata),
    .retire_v_i     (retire_v),
    .retire_npc_i   (retire_npc),
    .exc_i          (exc),
    .exc_tval_i     (exc_tval),
    .int_take_i     (int_take),
    .mret_i         (mret),
    .timer_irq_i    (timer_irq),
    .software_irq_i (sw_irq),
    .external_irq_i (ext_irq),
    .csr_rdata_o    (rdata),
    .csr_illegal_o  (illegal),
    .irq_pending_o  (irq_pending),
    .trap_v_o       (trap_v),
    .pc_o           (pc),
    .npc_o          (npc),
    .priv_o         (priv)
  );

  always #10 clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = 64'd0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
      $display("test failed");
      $fatal(1);
    end
  endtask

  function automatic logic [11:0] pick_addr(input int phase, input logic [2:0] sel);
    logic [95:0] t;
    case (phase)
      1: t = {12'h340, 12'h305, 12'h341, 12'h304, 12'h320, 12'h340, 12'h305, 12'h304};
      2: t = {12'h301, 12'hf12, 12'hf13, 12'h345, 12'h7c0, 12'h340, 12'h300, 12'hb00};
      3: t = {12'h305, 12'h340, 12'h341, 12'h342, 12'h343, 12'h300, 12'h305, 12'h341};
      4: t = {12'h304, 12'h300, 12'h344, 12'h304, 12'h300, 12'h342, 12'h340, 12'h305};
      5: t = {12'h300, 12'h341, 12'h342, 12'h300, 12'h341, 12'h340, 12'h305, 12'h304};
      default: t = {12'hb00, 12'hb02, 12'hc00, 12'hc02, 12'h320, 12'hb00, 12'hb02, 12'h320};
    endcase
    return t[int'(sel) * 12 +: 12];
  endfunction

  function automatic logic [63:0] model_read(input logic [11:0] a, output logic known);
    logic [63:0] v;
    known = 1'b1;
    v     = 64'd0;
    case (a)
      e_addr_cycle, e_addr_mcycle:     v = m_mcycle;
      e_addr_instret, e_addr_minstret: v = m_minstret;
      e_addr_mstatus:                  v = m_mstatus;
      e_addr_misa:                     v = `CSR_MISA_VALUE;
      e_addr_mie:                      v = m_mie;
      e_addr_mtvec:                    v = m_mtvec;
      e_addr_mcountinhibit:            v = m_inhibit;
      e_addr_mscratch:                 v = m_mscratch;
      e_addr_mepc:                     v = m_mepc;
      e_addr_mcause:                   v = m_mcause;
      e_addr_mtval:                    v = m_mtval;
      e_addr_mip:                      v = m_mip;
      e_addr_marchid:                  v = `CSR_MARCHID;
      e_addr_mimpid:                   v = `CSR_MIMPID;
      default:                         known = 1'b0;
    endcase
    return v;
  endfunction

  task automatic drive_inputs(input int phase);
    logic [2:0] r;
    logic [3:0] idx;
    r = 3'(rand_bits(3));
    // Opcode 4 is unused, fold it onto a plain read
    if (r == 3'd4)
      r = 3'd0;
    cmd_v      = 1'(rand_bits(2) != 64'd0);
    cmd_op     = csr_op_e'(r);
    cmd_addr   = pick_addr(phase, 3'(rand_bits(3)));
    cmd_wdata  = rand_bits(64);
    retire_v   = (phase >= 3) & 1'(rand_bits(1));
    retire_npc = 39'(rand_bits(39));
    exc_tval   = rand_bits(64);
    timer_irq  = (phase >= 4) & 1'(rand_bits(1));
    sw_irq     = (phase >= 4) & 1'(rand_bits(1));
    ext_irq    = (phase >= 4) & 1'(rand_bits(1));
    int_take   = (phase == 4 || phase == 5) & 1'(rand_bits(1));
    exc        = '0;
    if (phase >= 2 && phase <= 5 && rand_bits(2) == 64'd0)
    begin
      idx = 4'(rand_bits(4));
      if (idx > 4'd11)
        idx = idx - 4'd4;
      exc = rand_bits(1) != 64'd0 ? 12'd1 << idx : 12'(rand_bits(12));
    end
    mret = 1'b0;
    if ((phase == 2 || phase == 5) && rand_bits(2) == 64'd0)
    begin
      mret     = 1'b1;
      exc      = '0;
      int_take = 1'b0;
    end
  endtask

  task automatic check_and_update();
    logic [63:0] rd, wv, imm, pend, ms_old;
    logic        known, ill, gie, irq_p, take_int, trap, we;
    logic [3:0]  cause;
    logic [38:0] exp_npc;
    logic [1:0]  priv_old;
    rd       = model_read(cmd_addr, known);
    ill      = cmd_v & ((cmd_addr[9:8] > m_priv) | ~known);
    pend     = m_mie & m_mip;
    gie      = (m_priv == 2'b00) | m_mstatus[3];
    irq_p    = gie & (pend[3] | pend[7] | pend[11]);
    take_int = int_take & irq_p;
    trap     = take_int | (exc != 12'd0);
    cause    = 4'd0;
    if (take_int)
      cause = pend[3] ? 4'd3 : pend[7] ? 4'd7 : 4'd11;
    else
      for (int i = 11; i >= 0; i--)
        if (exc[i])
          cause = 4'(i);
    exp_npc = mret ? m_mepc[38:0] : trap ? {m_mtvec[38:2], 2'b00} : retire_v ? retire_npc : m_pc;

    check("rdata", rd, rdata);
    check("illegal", 64'(ill), 64'(illegal));
    check("irq_pending", 64'(irq_p), 64'(irq_pending));
    check("trap_v", 64'(trap), 64'(trap_v));
    check("npc", 64'(exp_npc), 64'(npc));
    check("pc", 64'(m_pc), 64'(pc));
    check("priv", 64'(m_priv), 64'(priv));

    ms_old   = m_mstatus;
    priv_old = m_priv;
    if (!m_inhibit[0])
      m_mcycle = m_mcycle + 64'd1;
    if (!m_inhibit[2] && retire_v)
      m_minstret = m_minstret + 64'd1;
    m_mip = {52'd0, ext_irq, 3'd0, timer_irq, 3'd0, sw_irq, 3'd0};

    imm = {59'd0, cmd_wdata[4:0]};
    case (cmd_op)
      e_csrrw:  wv = cmd_wdata;
      e_csrrs:  wv = rd | cmd_wdata;
      e_csrrc:  wv = rd & ~cmd_wdata;
      e_csrrwi: wv = imm;
      e_csrrsi: wv = rd | imm;
      e_csrrci: wv = rd & ~imm;
      default:  wv = rd;
    endcase
    we = cmd_v & ~ill & (cmd_op != e_csrr) & !(cmd_addr inside {e_addr_misa, e_addr_marchid,
         e_addr_mimpid, e_addr_mip, e_addr_cycle, e_addr_instret});
    if (we)
    begin
      case (cmd_addr)
        // Only MIE, MPIE and MPP exist, MPP is U or M
        e_addr_mstatus:       m_mstatus = {51'd0, {2{&wv[12:11]}}, 3'd0, wv[7], 3'd0, wv[3], 3'd0};
        e_addr_mie:           m_mie = wv & 64'h888;
        e_addr_mtvec:         m_mtvec = wv;
        e_addr_mscratch:      m_mscratch = wv;
        e_addr_mepc:          m_mepc = wv;
        e_addr_mcause:        m_mcause = wv;
        e_addr_mtval:         m_mtval = wv;
        e_addr_mcycle:        m_mcycle = wv;
        e_addr_minstret:      m_minstret = wv;
        e_addr_mcountinhibit: m_inhibit = wv & 64'h5;
        default:
        begin
        end
      endcase
    end

    if (mret)
    begin
      m_priv           = ms_old[12:11];
      m_mstatus[3]     = ms_old[7];
      m_mstatus[7]     = 1'b1;
      m_mstatus[12:11] = 2'b00;
    end
    else if (trap)
    begin
      m_priv           = 2'b11;
      m_mstatus[12:11] = priv_old;
      m_mstatus[7]     = ms_old[3];
      m_mstatus[3]     = 1'b0;
      m_mepc           = 64'(m_pc);
      m_mcause         = {take_int, 59'd0, cause};
      m_mtval          = take_int ? 64'd0 : exc_tval;
    end
    m_pc = exp_npc;
  endtask

  task automatic run_phase(input string name, input int phase);
    test_name = name;
    repeat (PHASE_CYCLES)
    begin
      drive_inputs(phase);
      #16;
      check_and_update();
      @(posedge clk);
      #2;
    end
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired before all tests finished");
    $display("test failed");
    $fatal(1);
  end

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b1;
    cmd_v      = 1'b0;
    cmd_op     = e_csrr;
    cmd_addr   = 12'd0;
    cmd_wdata  = 64'd0;
    retire_v   = 1'b0;
    retire_npc = 39'd0;
    exc        = '0;
    exc_tval   = 64'd0;
    int_take   = 1'b0;
    mret       = 1'b0;
    timer_irq  = 1'b0;
    sw_irq     = 1'b0;
    ext_irq    = 1'b0;
    m_priv     = 2'b11;
    m_pc       = `CSR_BOOT_PC;
    m_mstatus  = 64'd0;
    m_mie      = 64'd0;
    m_mip      = 64'd0;
    m_mtvec    = 64'd0;
    m_mscratch = 64'd0;
    m_mepc     = 64'd0;
    m_mcause   = 64'd0;
    m_mtval    = 64'd0;
    m_mcycle   = 64'd0;
    m_minstret = 64'd0;
    m_inhibit  = 64'd0;
    #2;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    run_phase("csr_rw", 1);
    run_phase("id_and_illegal", 2);
    run_phase("exceptions", 3);
    run_phase("interrupts", 4);
    run_phase("mret", 5);
    run_phase("counters", 6);

    if (DUT.u_props.fail_count == 0)
    begin
      $display("test passed");
      $finish;
    end
    else
    begin
      $display("bound assertions reported %0d failures", DUT.u_props.fail_count);
      $display("test failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
rtl/csr_isa_pkg.sv
rtl/csr_trap_pkg.sv
rtl/csr_access.sv
rtl/trap_ctrl.sv
rtl/csr_state.sv
rtl/csr_unit.sv
dv/csr_unit_properties.sv
dv/csr_unit_tb.sv

// ==== include/csr_settings.svh ====
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Datapath and address widths
`define CSR_XLEN 64
`define CSR_VADDR_WIDTH 39
`define CSR_ADDR_WIDTH 12

// First fetch address after reset
`define CSR_BOOT_PC 39'h00_8000_0000

// Identification registers
`define CSR_MARCHID 64'd13
`define CSR_MIMPID 64'd1

// MXLEN 64 with IMAFDSU
`define CSR_MISA_VALUE 64'h8000_0000_0014_1129

`endif

// ==== rtl/csr_access.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_access (
  input  wire logic                         csr_cmd_v_i,
  input  csr_isa_pkg::csr_op_e              csr_op_i,
  input  wire logic [`CSR_ADDR_WIDTH-1:0]   csr_addr_i,
  input  wire logic [`CSR_XLEN-1:0]         csr_wdata_i,
  input  csr_isa_pkg::priv_e                priv_i,
  input  wire logic [`CSR_XLEN-1:0]         mstatus_i,
  input  wire logic [`CSR_XLEN-1:0]         mie_i,
  input  wire logic [`CSR_XLEN-1:0]         mip_i,
  input  wire logic [`CSR_XLEN-1:0]         mtvec_i,
  input  wire logic [`CSR_XLEN-1:0]         mscratch_i,
  input  wire logic [`CSR_XLEN-1:0]         mepc_i,
  input  wire logic [`CSR_XLEN-1:0]         mcause_i,
  input  wire logic [`CSR_XLEN-1:0]         mtval_i,
  input  wire logic [`CSR_XLEN-1:0]         mcycle_i,
  input  wire logic [`CSR_XLEN-1:0]         minstret_i,
  input  wire logic [`CSR_XLEN-1:0]         mcountinhibit_i,
  output logic [`CSR_XLEN-1:0]              csr_rdata_o,
  output logic                              csr_illegal_o,
  output logic                              csr_we_o,
  output csr_isa_pkg::csr_addr_e            csr_waddr_o,
  output logic [`CSR_XLEN-1:0]              csr_wval_o
);

  import csr_isa_pkg::*;

  csr_addr_e               addr;
  logic                    unknown;
  logic                    priv_fail;
  logic                    ro_target;
  logic [`CSR_XLEN-1:0]    imm;

  assign addr = csr_addr_e'(csr_addr_i);
  assign imm  = {{(`CSR_XLEN-5){1'b0}}, csr_wdata_i[4:0]};

  // Bits 9:8 of the address give the lowest privilege allowed
  assign priv_fail = csr_addr_i[9:8] > priv_i;

  always_comb
  begin
    unknown = 1'b0;
    case (addr)
      e_addr_cycle,
      e_addr_mcycle:        csr_rdata_o = mcycle_i;
      e_addr_instret,
      e_addr_minstret:      csr_rdata_o = minstret_i;
      e_addr_mstatus:       csr_rdata_o = mstatus_i;
      e_addr_misa:          csr_rdata_o = `CSR_MISA_VALUE;
      e_addr_mie:           csr_rdata_o = mie_i;
      e_addr_mtvec:         csr_rdata_o = mtvec_i;
      e_addr_mcountinhibit: csr_rdata_o = mcountinhibit_i;
      e_addr_mscratch:      csr_rdata_o = mscratch_i;
      e_addr_mepc:          csr_rdata_o = mepc_i;
      e_addr_mcause:        csr_rdata_o = mcause_i;
      e_addr_mtval:         csr_rdata_o = mtval_i;
      e_addr_mip:           csr_rdata_o = mip_i;
      e_addr_marchid:       csr_rdata_o = `CSR_MARCHID;
      e_addr_mimpid:        csr_rdata_o = `CSR_MIMPID;
      default:
      begin
        csr_rdata_o = '0;
        unknown     = 1'b1;
      end
    endcase
  end

  always_comb
  begin
    case (csr_op_i)
      e_csrrw:  csr_wval_o = csr_wdata_i;
      e_csrrs:  csr_wval_o = csr_rdata_o | csr_wdata_i;
      e_csrrc:  csr_wval_o = csr_rdata_o & ~csr_wdata_i;
      e_csrrwi: csr_wval_o = imm;
      e_csrrsi: csr_wval_o = csr_rdata_o | imm;
      e_csrrci: csr_wval_o = csr_rdata_o & ~imm;
      default:  csr_wval_o = csr_rdata_o;
    endcase
  end

  // Writes here are dropped silently, user counter aliases included
  assign ro_target = addr inside {e_addr_misa, e_addr_marchid, e_addr_mimpid,
                                  e_addr_mip, e_addr_cycle, e_addr_instret};

  assign csr_illegal_o = csr_cmd_v_i & (priv_fail | unknown);
  assign csr_we_o      = csr_cmd_v_i & ~csr_illegal_o & (csr_op_i != e_csrr) & ~ro_target;
  assign csr_waddr_o   = addr;

endmodule

`default_nettype wire

// ==== rtl/csr_isa_pkg.sv ====
`default_nettype none

package csr_isa_pkg;

  // Low two bits follow funct3, bit 2 selects the immediate form
  typedef enum logic [2:0] {
    e_csrr   = 3'd0,
    e_csrrw  = 3'd1,
    e_csrrs  = 3'd2,
    e_csrrc  = 3'd3,
    e_csrrwi = 3'd5,
    e_csrrsi = 3'd6,
    e_csrrci = 3'd7
  } csr_op_e;

  typedef enum logic [11:0] {
    e_addr_cycle         = 12'hc00,
    e_addr_instret       = 12'hc02,
    e_addr_mstatus       = 12'h300,
    e_addr_misa          = 12'h301,
    e_addr_mie           = 12'h304,
    e_addr_mtvec         = 12'h305,
    e_addr_mcountinhibit = 12'h320,
    e_addr_mscratch      = 12'h340,
    e_addr_mepc          = 12'h341,
    e_addr_mcause        = 12'h342,
    e_addr_mtval         = 12'h343,
    e_addr_mip           = 12'h344,
    e_addr_mcycle        = 12'hb00,
    e_addr_minstret      = 12'hb02,
    e_addr_marchid       = 12'hf12,
    e_addr_mimpid        = 12'hf13
  } csr_addr_e;

  typedef enum logic [1:0] {
    e_priv_u = 2'b00,
    e_priv_m = 2'b11
  } priv_e;

endpackage

`default_nettype wire

// ==== rtl/csr_state.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_state (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,
  input  wire logic                          csr_we_i,
  input  csr_isa_pkg::csr_addr_e             csr_waddr_i,
  input  wire logic [`CSR_XLEN-1:0]          csr_wval_i,
  input  wire logic                          trap_v_i,
  input  wire logic                          trap_int_i,
  input  wire logic [3:0]                    trap_cause_i,
  input  wire logic                          mret_i,
  input  wire logic                          retire_v_i,
  input  wire logic [`CSR_VADDR_WIDTH-1:0]   retire_npc_i,
  input  wire logic [`CSR_XLEN-1:0]          exc_tval_i,
  input  wire logic                          timer_irq_i,
  input  wire logic                          software_irq_i,
  input  wire logic                          external_irq_i,
  output csr_isa_pkg::priv_e                 priv_o,
  output logic [`CSR_XLEN-1:0]               mstatus_o,
  output logic [`CSR_XLEN-1:0]               mie_o,
  output logic [`CSR_XLEN-1:0]               mip_o,
  output logic [`CSR_XLEN-1:0]               mtvec_o,
  output logic [`CSR_XLEN-1:0]               mscratch_o,
  output logic [`CSR_XLEN-1:0]               mepc_o,
  output logic [`CSR_XLEN-1:0]               mcause_o,
  output logic [`CSR_XLEN-1:0]               mtval_o,
  output logic [`CSR_XLEN-1:0]               mcycle_o,
  output logic [`CSR_XLEN-1:0]               minstret_o,
  output logic [`CSR_XLEN-1:0]               mcountinhibit_o,
  output logic [`CSR_VADDR_WIDTH-1:0]        pc_o,
  output logic [`CSR_VADDR_WIDTH-1:0]        npc_o
);

  import csr_isa_pkg::*;
  import csr_trap_pkg::*;

  // mstatus field positions
  localparam int mie_bit  = 3;
  localparam int mpie_bit = 7;
  localparam int mpp_lsb  = 11;

  localparam logic [`CSR_XLEN-1:0] mie_wmask = (`CSR_XLEN'(1) << e_irq_msi)
                                              | (`CSR_XLEN'(1) << e_irq_mti)
                                              | (`CSR_XLEN'(1) << e_irq_mei);

  priv_e                      priv_n;
  logic [`CSR_XLEN-1:0]       mstatus_n, mie_n, mip_n, mtvec_n, mscratch_n, mepc_n;
  logic [`CSR_XLEN-1:0]       mcause_n, mtval_n, mcycle_n, minstret_n, mcountinhibit_n;

  always_comb
  begin
    priv_n          = priv_o;
    mstatus_n       = mstatus_o;
    mie_n           = mie_o;
    mtvec_n         = mtvec_o;
    mscratch_n      = mscratch_o;
    mepc_n          = mepc_o;
    mcause_n        = mcause_o;
    mtval_n         = mtval_o;
    mcountinhibit_n = mcountinhibit_o;
    mcycle_n        = mcountinhibit_o[0] ? mcycle_o : mcycle_o + `CSR_XLEN'(1);
    minstret_n      = mcountinhibit_o[2] ? minstret_o : minstret_o + `CSR_XLEN'(retire_v_i);

    // Pending bits just follow the lines, one cycle late
    mip_n               = '0;
    mip_n[e_irq_msi]    = software_irq_i;
    mip_n[e_irq_mti]    = timer_irq_i;
    mip_n[e_irq_mei]    = external_irq_i;

    if (csr_we_i)
    begin
      case (csr_waddr_i)
        e_addr_mstatus:
        begin
          mstatus_n[mie_bit]                 = csr_wval_i[mie_bit];
          mstatus_n[mpie_bit]                = csr_wval_i[mpie_bit];
          // MPP holds only U or M
          mstatus_n[mpp_lsb+1:mpp_lsb]       = {2{&csr_wval_i[mpp_lsb+1:mpp_lsb]}};
        end
        e_addr_mie:           mie_n           = csr_wval_i & mie_wmask;
        e_addr_mtvec:         mtvec_n         = csr_wval_i;
        e_addr_mscratch:      mscratch_n      = csr_wval_i;
        e_addr_mepc:          mepc_n          = csr_wval_i;
        e_addr_mcause:        mcause_n        = csr_wval_i;
        e_addr_mtval:         mtval_n         = csr_wval_i;
        e_addr_mcycle:        mcycle_n        = csr_wval_i;
        e_addr_minstret:      minstret_n      = csr_wval_i;
        e_addr_mcountinhibit: mcountinhibit_n = csr_wval_i & `CSR_XLEN'(5);
        default:
        begin
        end
      endcase
    end

    if (mret_i)
    begin
      priv_n                           = priv_e'(mstatus_o[mpp_lsb+1:mpp_lsb]);
      mstatus_n[mie_bit]               = mstatus_o[mpie_bit];
      mstatus_n[mpie_bit]              = 1'b1;
      mstatus_n[mpp_lsb+1:mpp_lsb]     = e_priv_u;
    end
    else if (trap_v_i)
    begin
      priv_n                           = e_priv_m;
      mstatus_n[mpp_lsb+1:mpp_lsb]     = priv_o;
      mstatus_n[mpie_bit]              = mstatus_o[mie_bit];
      mstatus_n[mie_bit]               = 1'b0;
      mepc_n                           = `CSR_XLEN'(pc_o);
      mcause_n                         = {trap_int_i, {(`CSR_XLEN-5){1'b0}}, trap_cause_i};
      mtval_n                          = trap_int_i ? '0 : exc_tval_i;
    end
  end

  assign npc_o = mret_i     ? mepc_o[`CSR_VADDR_WIDTH-1:0]
               : trap_v_i   ? {mtvec_o[`CSR_VADDR_WIDTH-1:2], 2'b00}
               : retire_v_i ? retire_npc_i
               : pc_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      priv_o          <= e_priv_m;
      pc_o            <= `CSR_BOOT_PC;
      mstatus_o       <= '0;
      mie_o           <= '0;
      mip_o           <= '0;
      mtvec_o         <= '0;
      mscratch_o      <= '0;
      mepc_o          <= '0;
      mcause_o        <= '0;
      mtval_o         <= '0;
      mcycle_o        <= '0;
      minstret_o      <= '0;
      mcountinhibit_o <= '0;
    end
    else
    begin
      priv_o          <= priv_n;
      pc_o            <= npc_o;
      mstatus_o       <= mstatus_n;
      mie_o           <= mie_n;
      mip_o           <= mip_n;
      mtvec_o         <= mtvec_n;
      mscratch_o      <= mscratch_n;
      mepc_o          <= mepc_n;
      mcause_o        <= mcause_n;
      mtval_o         <= mtval_n;
      mcycle_o        <= mcycle_n;
      minstret_o      <= minstret_n;
      mcountinhibit_o <= mcountinhibit_n;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/csr_trap_pkg.sv ====
`default_nettype none

package csr_trap_pkg;

  // One-hot exception vector is indexed by the code below
  localparam int EXC_VEC_WIDTH = 12;

  typedef enum logic [3:0] {
    e_exc_instr_misaligned = 4'd0,
    e_exc_instr_fault      = 4'd1,
    e_exc_illegal_instr    = 4'd2,
    e_exc_breakpoint       = 4'd3,
    e_exc_load_misaligned  = 4'd4,
    e_exc_load_fault       = 4'd5,
    e_exc_store_misaligned = 4'd6,
    e_exc_store_fault      = 4'd7,
    e_exc_ecall_u          = 4'd8,
    e_exc_ecall_m          = 4'd11
  } exc_code_e;

  typedef enum logic [3:0] {
    e_irq_msi = 4'd3,
    e_irq_mti = 4'd7,
    e_irq_mei = 4'd11
  } irq_code_e;

endpackage

`default_nettype wire

// ==== rtl/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module csr_unit (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_n_i,
  input  wire logic                                  csr_cmd_v_i,
  input  csr_isa_pkg::csr_op_e                       csr_op_i,
  input  wire logic [`CSR_ADDR_WIDTH-1:0]            csr_addr_i,
  input  wire logic [`CSR_XLEN-1:0]                  csr_wdata_i,
  input  wire logic                                  retire_v_i,
  input  wire logic [`CSR_VADDR_WIDTH-1:0]           retire_npc_i,
  input  wire logic [csr_trap_pkg::EXC_VEC_WIDTH-1:0] exc_i,
  input  wire logic [`CSR_XLEN-1:0]                  exc_tval_i,
  input  wire logic                                  int_take_i,
  input  wire logic                                  mret_i,
  input  wire logic                                  timer_irq_i,
  input  wire logic                                  software_irq_i,
  input  wire logic                                  external_irq_i,
  output logic [`CSR_XLEN-1:0]                       csr_rdata_o,
  output logic                                       csr_illegal_o,
  output logic                                       irq_pending_o,
  output logic                                       trap_v_o,
  output logic [`CSR_VADDR_WIDTH-1:0]                pc_o,
  output logic [`CSR_VADDR_WIDTH-1:0]                npc_o,
  output csr_isa_pkg::priv_e                         priv_o
);

  import csr_isa_pkg::*;

  logic                 csr_we;
  csr_addr_e            csr_waddr;
  logic [`CSR_XLEN-1:0] csr_wval;
  logic                 trap_int;
  logic [3:0]           trap_cause;
  logic [`CSR_XLEN-1:0] mstatus, mie, mip, mtvec, mscratch, mepc;
  logic [`CSR_XLEN-1:0] mcause, mtval, mcycle, minstret, mcountinhibit;

  csr_access u_access (
    .csr_cmd_v_i     (csr_cmd_v_i),
    .csr_op_i        (csr_op_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wdata_i     (csr_wdata_i),
    .priv_i          (priv_o),
    .mstatus_i       (mstatus),
    .mie_i           (mie),
    .mip_i           (mip),
    .mtvec_i         (mtvec),
    .mscratch_i      (mscratch),
    .mepc_i          (mepc),
    .mcause_i        (mcause),
    .mtval_i         (mtval),
    .mcycle_i        (mcycle),
    .minstret_i      (minstret),
    .mcountinhibit_i (mcountinhibit),
    .csr_rdata_o     (csr_rdata_o),
    .csr_illegal_o   (csr_illegal_o),
    .csr_we_o        (csr_we),
    .csr_waddr_o     (csr_waddr),
    .csr_wval_o      (csr_wval)
  );

  trap_ctrl u_trap (
    .exc_i           (exc_i),
    .int_take_i      (int_take_i),
    .priv_i          (priv_o),
    .mstatus_mie_i   (mstatus[3]),
    .mie_i           (mie),
    .mip_i           (mip),
    .trap_v_o        (trap_v_o),
    .trap_int_o      (trap_int),
    .trap_cause_o    (trap_cause),
    .irq_pending_o   (irq_pending_o)
  );

  csr_state u_state (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .csr_we_i        (csr_we),
    .csr_waddr_i     (csr_waddr),
    .csr_wval_i      (csr_wval),
    .trap_v_i        (trap_v_o),
    .trap_int_i      (trap_int),
    .trap_cause_i    (trap_cause),
    .mret_i          (mret_i),
    .retire_v_i      (retire_v_i),
    .retire_npc_i    (retire_npc_i),
    .exc_tval_i      (exc_tval_i),
    .timer_irq_i     (timer_irq_i),
    .software_irq_i  (software_irq_i),
    .external_irq_i  (external_irq_i),
    .priv_o          (priv_o),
    .mstatus_o       (mstatus),
    .mie_o           (mie),
    .mip_o           (mip),
    .mtvec_o         (mtvec),
    .mscratch_o      (mscratch),
    .mepc_o          (mepc),
    .mcause_o        (mcause),
    .mtval_o         (mtval),
    .mcycle_o        (mcycle),
    .minstret_o      (minstret),
    .mcountinhibit_o (mcountinhibit),
    .pc_o            (pc_o),
    .npc_o           (npc_o)
  );

endmodule

`default_nettype wire

// ==== rtl/trap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_settings.svh"

module trap_ctrl (
  input  wire logic [csr_trap_pkg::EXC_VEC_WIDTH-1:0] exc_i,
  input  wire logic                                  int_take_i,
  input  csr_isa_pkg::priv_e                         priv_i,
  input  wire logic                                  mstatus_mie_i,
  input  wire logic [`CSR_XLEN-1:0]                  mie_i,
  input  wire logic [`CSR_XLEN-1:0]                  mip_i,
  output logic                                       trap_v_o,
  output logic                                       trap_int_o,
  output logic [3:0]                                 trap_cause_o,
  output logic                                       irq_pending_o
);

  import csr_isa_pkg::*;
  import csr_trap_pkg::*;

  logic [`CSR_XLEN-1:0] irq_masked;
  logic                 gie;
  irq_code_e            irq_code;
  exc_code_e            exc_code;

  assign irq_masked = mie_i & mip_i;

  // M-mode interrupts are always enabled while running in U
  assign gie = (priv_i == e_priv_u) | ((priv_i == e_priv_m) & mstatus_mie_i);

  // Lowest code wins
  always_comb
  begin
    if (irq_masked[e_irq_msi])
      irq_code = e_irq_msi;
    else if (irq_masked[e_irq_mti])
      irq_code = e_irq_mti;
    else
      irq_code = e_irq_mei;
  end

  assign irq_pending_o = gie & (irq_masked[e_irq_msi] | irq_masked[e_irq_mti]
                                | irq_masked[e_irq_mei]);

  always_comb
  begin
    exc_code = e_exc_instr_misaligned;
    for (int i = EXC_VEC_WIDTH - 1; i >= 0; i--)
    begin
      if (exc_i[i])
        exc_code = exc_code_e'(i);
    end
  end

  assign trap_int_o   = int_take_i & irq_pending_o;
  assign trap_v_o     = trap_int_o | (|exc_i);
  assign trap_cause_o = trap_int_o ? irq_code : exc_code;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module csr_unit_tb \
  --Mdir obj_dir -o sim_csr_unit

./obj_dir/sim_csr_unit +verilator+error+limit+100 | tee sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation PASS"
else
  echo "simulation FAIL, see sim.log" >&2
  exit 1
fi
